/* compile.f */
+incdir+include
logic/tone_pkg.sv
logic/cordic_rotator.sv
logic/tone_channel.sv
logic/tone_mixer.sv
logic/axil_regs.sv
logic/dual_tone_top.sv
dv/tb_dual_tone.sv

/* dv/tb_dual_tone.sv */
// Testbench for the dual-tone sine generator
// Configures the generator over AXI4-Lite and checks every output
// sample against a bit-exact CORDIC and mixer model

`include "tone_params.svh"

module tb_dual_tone;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int  c_nr_cfg  = 8;
  localparam int  c_nr_samp = 12;
  localparam int  c_frame   = `TONE_NR_ITER + 2;
  localparam int  c_timeout = c_nr_cfg * c_nr_samp * c_frame + 2000;
  localparam real c_pi      = 3.141592653589793;

  logic                      i_clk;
  logic                      i_rst_an;
  logic [`AXIL_ADDR_W-1:0]   i_awaddr;
  logic                      i_awvalid;
  logic                      o_awready;
  logic [`AXIL_DATA_W-1:0]   i_wdata;
  logic [`AXIL_DATA_W/8-1:0] i_wstrb;
  logic                      i_wvalid;
  logic                      o_wready;
  tone_pkg::axil_resp_t      o_bresp;
  logic                      o_bvalid;
  logic                      i_bready;
  logic [`AXIL_ADDR_W-1:0]   i_araddr;
  logic                      i_arvalid;
  logic                      o_arready;
  logic [`AXIL_DATA_W-1:0]   o_rdata;
  tone_pkg::axil_resp_t      o_rresp;
  logic                      o_rvalid;
  logic                      i_rready;
  tone_pkg::sample_t         o_sample;
  logic                      o_sample_valid;
  logic                      o_sat;

  // Register mirror and model state
  logic [15:0]      mir_cfg [0:3];
  logic             mir_enable;
  tone_pkg::phase_t mdl_phase_a;
  tone_pkg::phase_t mdl_phase_b;
  tone_pkg::phase_t mdl_step_a;
  tone_pkg::phase_t mdl_step_b;
  bit               run_first;
  int               samples_seen = 0;
  int               last_sample_cycle = 0;
  int               cycle_cnt = 0;
  int               sample_errs = 0;
  int               resp_errs = 0;
  int               data_errs = 0;
  int               other_errs = 0;

  dual_tone_top dual_tone_top_inst (.*);

  always #2 i_clk = ~i_clk;

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  function automatic tone_pkg::sample_t cordic_sin(input tone_pkg::phase_t phase);
    logic signed [19:0] x;
    logic signed [19:0] y;
    logic signed [19:0] x_prev;
    logic signed [15:0] z;
    logic signed [15:0] atan_i;
    // Quadrants 01 and 10 start from the negative x axis
    if (phase[15] != phase[14])
    begin
      x = -(20'sd16384 <<< `TONE_EXT_BITS);
      z = phase - 16'h8000;
    end
    else
    begin
      x = 20'sd16384 <<< `TONE_EXT_BITS;
      z = phase;
    end
    y = '0;
    for (int i = 0; i < `TONE_NR_ITER; i++)
    begin
      atan_i = 16'($rtoi($atan(2.0 ** (-i)) * 65536.0 / (2.0 * c_pi) + 0.5));
      x_prev = x;
      if (!z[15])
      begin
        x = x - (y >>> i);
        y = y + (x_prev >>> i);
        z = z - atan_i;
      end
      else
      begin
        x = x + (y >>> i);
        y = y - (x_prev >>> i);
        z = z + atan_i;
      end
    end
    return tone_pkg::sample_t'(y >>> `TONE_EXT_BITS);
  endfunction

  function automatic tone_pkg::sample_t mix_model(
    input  tone_pkg::sample_t sin_a,
    input  tone_pkg::sample_t sin_b,
    input  tone_pkg::amp_t    amp_a,
    input  tone_pkg::amp_t    amp_b,
    output logic              sat
  );
    int comp_a;
    int comp_b;
    int sum;
    comp_a = (int'(sin_a) * 19898) >>> 15;
    comp_b = (int'(sin_b) * 19898) >>> 15;
    sum    = ((comp_a * int'(amp_a)) >>> 15) + ((comp_b * int'(amp_b)) >>> 15);
    sat    = (sum > 32767) || (sum < -32768);
    if (sum > 32767)
      return 16'sh7FFF;
    else if (sum < -32768)
      return 16'sh8000;
    return tone_pkg::sample_t'(sum);
  endfunction

  function automatic logic is_mapped(input logic [4:0] addr);
    return addr inside {`REG_CTRL, `REG_FREQ_A, `REG_FREQ_B, `REG_AMP_A, `REG_AMP_B,
                        `REG_COUNT};
  endfunction

  function automatic logic [31:0] read_model(input logic [4:0] addr);
    case (addr)
      `REG_CTRL:   return {31'b0, mir_enable};
      `REG_FREQ_A: return {16'b0, mir_cfg[0]};
      `REG_FREQ_B: return {16'b0, mir_cfg[1]};
      `REG_AMP_A:  return {16'b0, mir_cfg[2]};
      `REG_AMP_B:  return {16'b0, mir_cfg[3]};
      `REG_COUNT:  return 32'(samples_seen);
      default:     return '0;
    endcase
  endfunction

  // Low two bytes of a config word under the write strobes
  function automatic logic [15:0] merge_bytes(input logic [15:0] old_val,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb);
    logic [15:0] merged;
    merged = old_val;
    for (int b = 0; b < 2; b++)
    begin
      if (strb[b])
        merged[8*b +: 8] = data[8*b +: 8];
    end
    return merged;
  endfunction

  function automatic int cfg_index(input logic [4:0] addr);
    return (addr >> 2) - 1;
  endfunction

  // ---------------------------------------------------------------------------
  // Compare tasks
  // ---------------------------------------------------------------------------
  task automatic check_sample(input tone_pkg::sample_t got, input tone_pkg::sample_t exp,
                              input logic got_sat, input logic exp_sat);
    if (got !== exp)
    begin
      $display("Error: o_sample got 0x%h expected 0x%h", got, exp);
      sample_errs++;
    end
    if (got_sat !== exp_sat)
    begin
      $display("Error: o_sat got 0x%h expected 0x%h", got_sat, exp_sat);
      sample_errs++;
    end
  endtask

  task automatic check_resp(input string name, input logic [4:0] addr,
                            input tone_pkg::axil_resp_t got, input tone_pkg::axil_resp_t exp);
    if (got !== exp)
    begin
      $display("Error: %s at 0x%h got 0x%h expected 0x%h", name, addr, got, exp);
      resp_errs++;
    end
  endtask

  task automatic check_data(input string name, input logic [4:0] addr,
                            input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Error: %s at 0x%h got 0x%h expected 0x%h", name, addr, got, exp);
      data_errs++;
    end
  endtask

  // ---------------------------------------------------------------------------
  // Monitors and run limit
  // ---------------------------------------------------------------------------
  task automatic score_sample();
    tone_pkg::sample_t exp_sample;
    logic              exp_sat;
    exp_sample = mix_model(cordic_sin(mdl_phase_a), cordic_sin(mdl_phase_b),
                           tone_pkg::amp_t'(mir_cfg[2]), tone_pkg::amp_t'(mir_cfg[3]), exp_sat);
    check_sample(o_sample, exp_sample, o_sat, exp_sat);
    if (!run_first && (cycle_cnt - last_sample_cycle != c_frame))
    begin
      $display("Samples arrived %0d cycles apart instead of %0d",
               cycle_cnt - last_sample_cycle, c_frame);
      other_errs++;
    end
    run_first         = 1'b0;
    last_sample_cycle = cycle_cnt;
    // This edge is also the next load, which picks up the current word
    mdl_phase_a  = mdl_phase_a + mdl_step_a;
    mdl_phase_b  = mdl_phase_b + mdl_step_b;
    mdl_step_a   = mir_cfg[0];
    mdl_step_b   = mir_cfg[1];
    samples_seen <= samples_seen + 1;
  endtask

  always @(posedge i_clk)
  begin
    if (i_rst_an && o_sample_valid)
      score_sample();
  end

  // Mirror takes each write at its handshake edge, as the registers do
  always @(posedge i_clk)
  begin
    if (i_rst_an && i_awvalid && i_wvalid && o_awready)
    begin
      if (i_awaddr == `REG_CTRL && i_wstrb[0])
        mir_enable <= i_wdata[0];
      if (i_awaddr >= `REG_FREQ_A && i_awaddr <= `REG_AMP_B && i_awaddr[1:0] == 2'b00)
        mir_cfg[cfg_index(i_awaddr)] <= merge_bytes(mir_cfg[cfg_index(i_awaddr)],
                                                    i_wdata, i_wstrb);
    end
  end

  always @(posedge i_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= c_timeout)
    begin
      $display("Run stopped after %0d cycles without reaching the end", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // AXI4-Lite driver
  // ---------------------------------------------------------------------------
  task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output tone_pkg::axil_resp_t resp);
    i_awaddr  <= addr;
    i_awvalid <= 1'b1;
    i_wdata   <= data;
    i_wstrb   <= strb;
    i_wvalid  <= 1'b1;
    do @(posedge i_clk); while (!o_awready);
    if (o_wready !== 1'b1)
    begin
      $display("Error: o_wready got 0x%h expected 0x1", o_wready);
      other_errs++;
    end
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
    repeat ($urandom_range(0, 3)) @(posedge i_clk);
    i_bready <= 1'b1;
    do @(posedge i_clk); while (!o_bvalid);
    resp     = o_bresp;
    i_bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                          output tone_pkg::axil_resp_t resp);
    i_araddr  <= addr;
    i_arvalid <= 1'b1;
    do @(posedge i_clk); while (!o_arready);
    i_arvalid <= 1'b0;
    repeat ($urandom_range(0, 3)) @(posedge i_clk);
    i_rready <= 1'b1;
    do @(posedge i_clk); while (!o_rvalid);
    data     = o_rdata;
    resp     = o_rresp;
    i_rready <= 1'b0;
  endtask

  task automatic reg_write(input logic [4:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    tone_pkg::axil_resp_t got_resp;
    axi_write(addr, data, strb, got_resp);
    check_resp("o_bresp", addr, got_resp, is_mapped(addr) ? tone_pkg::OKAY : tone_pkg::SLVERR);
  endtask

  task automatic reg_read(input logic [4:0] addr);
    logic [31:0]          got_data;
    tone_pkg::axil_resp_t got_resp;
    axi_read(addr, got_data, got_resp);
    check_resp("o_rresp", addr, got_resp, is_mapped(addr) ? tone_pkg::OKAY : tone_pkg::SLVERR);
    check_data("o_rdata", addr, got_data, read_model(addr));
  endtask

  // ---------------------------------------------------------------------------
  // Tone sequences
  // ---------------------------------------------------------------------------
  task automatic set_config(input tone_pkg::phase_t freq_a, input tone_pkg::phase_t freq_b,
                            input tone_pkg::amp_t amp_a, input tone_pkg::amp_t amp_b);
    reg_write(`REG_FREQ_A, {16'($urandom), freq_a}, 4'hF);
    reg_write(`REG_FREQ_B, {16'($urandom), freq_b}, 4'hF);
    reg_write(`REG_AMP_A, {16'($urandom), amp_a}, 4'hF);
    reg_write(`REG_AMP_B, {16'($urandom), amp_b}, 4'hF);
  endtask

  task automatic start_tones();
    // Both phases restart at 0 and the first load uses the current words
    mdl_phase_a = '0;
    mdl_phase_b = '0;
    mdl_step_a  = mir_cfg[0];
    mdl_step_b  = mir_cfg[1];
    run_first   = 1'b1;
    reg_write(`REG_CTRL, 32'h1, 4'h1);
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = samples_seen + n;
    while (samples_seen < target)
      @(posedge i_clk);
  endtask

  task automatic stop_tones();
    int quiet;
    reg_write(`REG_CTRL, 32'h0, 4'h1);
    // A frame in flight still completes, so wait for two silent frames
    quiet = 0;
    while (quiet < 2 * c_frame)
    begin
      @(posedge i_clk);
      quiet = o_sample_valid ? 0 : quiet + 1;
    end
  endtask

  task automatic run_tones(input tone_pkg::phase_t freq_a, input tone_pkg::phase_t freq_b,
                           input tone_pkg::amp_t amp_a, input tone_pkg::amp_t amp_b);
    set_config(freq_a, freq_b, amp_a, amp_b);
    start_tones();
    wait_samples(c_nr_samp);
    stop_tones();
  endtask

  // ---------------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------------
  initial
  begin
    logic [4:0]  addr;
    logic [31:0] data;
    int          total;
    i_clk      = 1'b0;
    i_rst_an   = 1'b0;
    i_awaddr   = '0;
    i_awvalid  = 1'b0;
    i_wdata    = '0;
    i_wstrb    = '0;
    i_wvalid   = 1'b0;
    i_bready   = 1'b0;
    i_araddr   = '0;
    i_arvalid  = 1'b0;
    i_rready   = 1'b0;
    mir_enable = 1'b0;
    mir_cfg    = '{default: '0};
    void'($urandom(32'h63d9));
    repeat (3) @(posedge i_clk);
    i_rst_an <= 1'b1;
    @(posedge i_clk);

    // Reset state
    if ({o_awready, o_wready, o_bvalid, o_arready, o_rvalid, o_sample_valid, o_sat} !== '0)
    begin
      $display("Error: ready, valid and o_sat flags after reset got 0x%h expected 0x00",
               {o_awready, o_wready, o_bvalid, o_arready, o_rvalid, o_sample_valid, o_sat});
      other_errs++;
    end
    for (int r = 0; r < 6; r++)
      reg_read(5'(4 * r));

    // Byte-strobed writes with the enable kept off
    for (int n = 0; n < 24; n++)
    begin
      addr    = 5'(4 * $urandom_range(0, 4));
      data    = $urandom;
      data[0] = 1'b0;
      reg_write(addr, data, 4'($urandom));
      reg_read(addr);
    end
    for (int n = 0; n < 4; n++)
    begin
      addr = 5'h18 + 5'($urandom_range(0, 7));
      reg_write(addr, $urandom, 4'hF);
      reg_read(addr);
    end

    // Single tone with one frequency word per quadrant
    for (int q = 0; q < 4; q++)
      run_tones({2'(q), 14'($urandom)}, 16'($urandom), 16'($urandom), 16'sd0);

    // Two tones at random amplitudes, near full scale and at clipping peaks
    run_tones(16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom));
    run_tones(16'($urandom), 16'($urandom), 16'sh7FFF, 16'sh8000);
    run_tones(16'h4000, 16'h4000, 16'sh8000, 16'sh8000);

    // Frequency change while running
    set_config(16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom));
    start_tones();
    reg_read(`REG_CTRL);
    wait_samples(4);
    reg_write(`REG_FREQ_A, $urandom, 4'h3);
    reg_write(`REG_FREQ_B, $urandom, 4'h3);
    wait_samples(c_nr_samp - 4);
    stop_tones();

    // Sample count is read-only
    reg_write(`REG_COUNT, $urandom, 4'hF);
    reg_read(`REG_COUNT);
    reg_read(`REG_CTRL);

    total = sample_errs + resp_errs + data_errs + other_errs;
    $display("Errors: sample %0d, response %0d, data %0d, other %0d over %0d samples",
             sample_errs, resp_errs, data_errs, other_errs, samples_seen);
    if (total == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* include/tone_params.svh */
// Dual-tone generator parameters
// Widths, CORDIC iteration count and AXI4-Lite register map

`ifndef TONE_PARAMS_SVH
`define TONE_PARAMS_SVH

// Datapath widths with a full circle of 2^16 phase steps
`define TONE_PHASE_W  16
`define TONE_XY_W     16
`define TONE_NR_ITER  16
`define TONE_EXT_BITS 4

// AXI4-Lite bus
`define AXIL_ADDR_W   5
`define AXIL_DATA_W   32

// Register offsets
`define REG_CTRL      5'h00
`define REG_FREQ_A    5'h04
`define REG_FREQ_B    5'h08
`define REG_AMP_A     5'h0C
`define REG_AMP_B     5'h10
`define REG_COUNT     5'h14

`endif

/* logic/axil_regs.sv */
// AXI4-Lite register bank for the dual-tone generator
// Holds enable, frequency words and amplitudes, counts output samples

`include "tone_params.svh"

module axil_regs (
  input  logic                      i_clk,
  input  logic                      i_rst_an,
  input  logic [`AXIL_ADDR_W-1:0]   i_awaddr,
  input  logic                      i_awvalid,
  output logic                      o_awready,
  input  logic [`AXIL_DATA_W-1:0]   i_wdata,
  input  logic [`AXIL_DATA_W/8-1:0] i_wstrb,
  input  logic                      i_wvalid,
  output logic                      o_wready,
  output tone_pkg::axil_resp_t      o_bresp,
  output logic                      o_bvalid,
  input  logic                      i_bready,
  input  logic [`AXIL_ADDR_W-1:0]   i_araddr,
  input  logic                      i_arvalid,
  output logic                      o_arready,
  output logic [`AXIL_DATA_W-1:0]   o_rdata,
  output tone_pkg::axil_resp_t      o_rresp,
  output logic                      o_rvalid,
  input  logic                      i_rready,
  input  logic                      i_sample_valid,
  output logic                      o_enable,
  output tone_pkg::phase_t          o_freq_a,
  output tone_pkg::phase_t          o_freq_b,
  output tone_pkg::amp_t            o_amp_a,
  output tone_pkg::amp_t            o_amp_b
);

  localparam int c_cfg_w = `TONE_PHASE_W;

  // Config words 0..3 are FREQ_A, FREQ_B, AMP_A, AMP_B
  logic [c_cfg_w-1:0]      r_cfg [0:3];
  logic [`AXIL_DATA_W-1:0] r_count;
  logic [`AXIL_DATA_W-1:0] rd_data;
  logic                    rd_err;
  logic                    wr_err;
  logic                    wr_cfg;
  logic [1:0]              wr_idx;
  logic                    wr_fire;
  logic                    rd_fire;

  assign wr_fire = o_awready && i_awvalid && i_wvalid;
  assign rd_fire = o_arready && i_arvalid;
  assign o_wready = o_awready;

  // -------------------------------------------------------------------------
  // Address decode
  // -------------------------------------------------------------------------
  assign wr_cfg = (i_awaddr >= `REG_FREQ_A) && (i_awaddr <= `REG_AMP_B)
                  && (i_awaddr[1:0] == 2'b00);
  assign wr_idx = 2'(i_awaddr[4:2] - 3'd1);
  assign wr_err = !(wr_cfg || i_awaddr == `REG_CTRL || i_awaddr == `REG_COUNT);

  always_comb
  begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (i_araddr)
      `REG_CTRL:   rd_data = {{(`AXIL_DATA_W-1){1'b0}}, o_enable};
      `REG_FREQ_A: rd_data = `AXIL_DATA_W'(r_cfg[0]);
      `REG_FREQ_B: rd_data = `AXIL_DATA_W'(r_cfg[1]);
      `REG_AMP_A:  rd_data = `AXIL_DATA_W'(r_cfg[2]);
      `REG_AMP_B:  rd_data = `AXIL_DATA_W'(r_cfg[3]);
      `REG_COUNT:  rd_data = r_count;
      default:     rd_err  = 1'b1;
    endcase
  end

  // -------------------------------------------------------------------------
  // Handshakes, registers and sample counter
  // -------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      o_awready <= 1'b0;
      o_bvalid  <= 1'b0;
      o_bresp   <= tone_pkg::OKAY;
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
      o_rresp   <= tone_pkg::OKAY;
      o_rdata   <= '0;
      o_enable  <= 1'b0;
      r_cfg     <= '{default: '0};
      r_count   <= '0;
    end
    else
    begin
      // One-cycle ready once both channels are valid and no response waits
      o_awready <= i_awvalid && i_wvalid && !o_bvalid && !o_awready;
      o_arready <= i_arvalid && !o_rvalid && !o_arready;

      if (wr_fire)
      begin
        o_bvalid <= 1'b1;
        o_bresp  <= wr_err ? tone_pkg::SLVERR : tone_pkg::OKAY;
        if (i_awaddr == `REG_CTRL && i_wstrb[0])
          o_enable <= i_wdata[0];
        if (wr_cfg)
        begin
          for (int b = 0; b < c_cfg_w / 8; b++)
          begin
            if (i_wstrb[b])
              r_cfg[wr_idx][8*b +: 8] <= i_wdata[8*b +: 8];
          end
        end
      end
      else if (o_bvalid && i_bready)
      begin
        o_bvalid <= 1'b0;
      end

      if (rd_fire)
      begin
        o_rvalid <= 1'b1;
        o_rdata  <= rd_data;
        o_rresp  <= rd_err ? tone_pkg::SLVERR : tone_pkg::OKAY;
      end
      else if (o_rvalid && i_rready)
      begin
        o_rvalid <= 1'b0;
      end

      if (i_sample_valid)
        r_count <= r_count + 1'b1;
    end
  end

  assign o_freq_a = r_cfg[0];
  assign o_freq_b = r_cfg[1];
  assign o_amp_a  = r_cfg[2];
  assign o_amp_b  = r_cfg[3];

  a_bvalid_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_an)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

  a_rvalid_hold: assert property (
    @(posedge i_clk) disable iff (!i_rst_an)
    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

endmodule

/* logic/cordic_rotator.sv */
// Iterative rotation-mode CORDIC
// One shared add/shift stage runs nr_iter micro-rotations per start.
// Quadrant pre-rotation lets any 16-bit phase converge.

`include "tone_params.svh"

module cordic_rotator #(
  parameter int nr_iter = `TONE_NR_ITER
) (
  input  logic              i_clk,
  input  logic              i_rst_an,
  input  logic              i_start,
  input  tone_pkg::phase_t  i_phase,
  output tone_pkg::sample_t o_sin,
  output logic              o_done
);

  localparam int c_ext_bits = `TONE_EXT_BITS;
  localparam int c_xy_w     = `TONE_XY_W + c_ext_bits;
  localparam int c_z_w      = `TONE_PHASE_W;
  localparam int c_cnt_w    = $clog2(nr_iter);

  localparam logic [c_cnt_w-1:0] c_last = c_cnt_w'(nr_iter - 1);

  // Start vector 16384 with guard bits and a half turn for the residual angle
  localparam logic signed [c_xy_w-1:0] c_x_start = c_xy_w'(16384 * (2 ** c_ext_bits));
  localparam tone_pkg::phase_t         c_half    = tone_pkg::phase_t'(1 << (c_z_w - 1));

  // -------------------------------------------------------------------------
  // Arctangent table of round(atan(2^-i) * 2^16 / 2pi)
  // -------------------------------------------------------------------------
  typedef logic signed [c_z_w-1:0] atan_tab_t [0:nr_iter-1];

  function automatic atan_tab_t build_atan();
    atan_tab_t tab;
    for (int i = 0; i < nr_iter; i++)
    begin
      tab[i] = c_z_w'($rtoi($atan(2.0 ** (-i)) * 65536.0 / (2.0 * 3.141592653589793) + 0.5));
    end
    return tab;
  endfunction

  localparam atan_tab_t c_atan = build_atan();

  logic signed [c_xy_w-1:0] r_x;
  logic signed [c_xy_w-1:0] r_y;
  logic signed [c_z_w-1:0]  r_z;
  logic [c_cnt_w-1:0]       r_iter;
  logic                     r_busy;
  logic                     flip;
  logic                     rot_pos;
  logic signed [c_xy_w-1:0] x_shift;
  logic signed [c_xy_w-1:0] y_shift;

  // Second and third quadrant start from -x
  assign flip = i_phase[c_z_w-1] ^ i_phase[c_z_w-2];

  // Shared micro-rotation stage
  assign rot_pos = ~r_z[c_z_w-1];
  assign x_shift = r_x >>> r_iter;
  assign y_shift = r_y >>> r_iter;

  // Control state
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      r_busy <= 1'b0;
      r_iter <= '0;
      o_done <= 1'b0;
    end
    else
    begin
      o_done <= 1'b0;
      if (i_start)
      begin
        r_busy <= 1'b1;
        r_iter <= '0;
      end
      else if (r_busy)
      begin
        if (r_iter == c_last)
        begin
          r_busy <= 1'b0;
          r_iter <= '0;
          o_done <= 1'b1;
        end
        else
        begin
          r_iter <= r_iter + 1'b1;
        end
      end
    end
  end

  // Vector and residual angle
  always_ff @(posedge i_clk)
  begin
    if (i_start)
    begin
      r_x <= flip ? -c_x_start : c_x_start;
      r_y <= '0;
      r_z <= flip ? i_phase - c_half : i_phase;
    end
    else if (r_busy)
    begin
      r_x <= rot_pos ? r_x - y_shift : r_x + y_shift;
      r_y <= rot_pos ? r_y + x_shift : r_y - x_shift;
      r_z <= rot_pos ? r_z - c_atan[r_iter] : r_z + c_atan[r_iter];
    end
  end

  // Drop the guard bits
  assign o_sin = r_y[c_xy_w-1:c_ext_bits];

  a_no_start_while_busy: assert property (
    @(posedge i_clk) disable iff (!i_rst_an) i_start |-> !r_busy);

  a_iter_bound: assert property (
    @(posedge i_clk) disable iff (!i_rst_an)
    i_start |=> (r_busy && r_iter <= c_last) [*nr_iter] ##1 o_done);

endmodule

/* logic/dual_tone_top.sv */
// Dual-tone sine generator top level
// AXI4-Lite register bank, two CORDIC tone channels and the mixer

`include "tone_params.svh"

module dual_tone_top (
  input  logic                      i_clk,
  input  logic                      i_rst_an,
  input  logic [`AXIL_ADDR_W-1:0]   i_awaddr,
  input  logic                      i_awvalid,
  output logic                      o_awready,
  input  logic [`AXIL_DATA_W-1:0]   i_wdata,
  input  logic [`AXIL_DATA_W/8-1:0] i_wstrb,
  input  logic                      i_wvalid,
  output logic                      o_wready,
  output tone_pkg::axil_resp_t      o_bresp,
  output logic                      o_bvalid,
  input  logic                      i_bready,
  input  logic [`AXIL_ADDR_W-1:0]   i_araddr,
  input  logic                      i_arvalid,
  output logic                      o_arready,
  output logic [`AXIL_DATA_W-1:0]   o_rdata,
  output tone_pkg::axil_resp_t      o_rresp,
  output logic                      o_rvalid,
  input  logic                      i_rready,
  output tone_pkg::sample_t         o_sample,
  output logic                      o_sample_valid,
  output logic                      o_sat
);

  logic              enable;
  tone_pkg::phase_t  freq_a;
  tone_pkg::phase_t  freq_b;
  tone_pkg::amp_t    amp_a;
  tone_pkg::amp_t    amp_b;
  tone_pkg::sample_t sin_a;
  tone_pkg::sample_t sin_b;
  logic              valid_a;
  logic              valid_b;

  axil_regs axil_regs_inst (
    .i_clk          (i_clk),
    .i_rst_an       (i_rst_an),
    .i_awaddr       (i_awaddr),
    .i_awvalid      (i_awvalid),
    .o_awready      (o_awready),
    .i_wdata        (i_wdata),
    .i_wstrb        (i_wstrb),
    .i_wvalid       (i_wvalid),
    .o_wready       (o_wready),
    .o_bresp        (o_bresp),
    .o_bvalid       (o_bvalid),
    .i_bready       (i_bready),
    .i_araddr       (i_araddr),
    .i_arvalid      (i_arvalid),
    .o_arready      (o_arready),
    .o_rdata        (o_rdata),
    .o_rresp        (o_rresp),
    .o_rvalid       (o_rvalid),
    .i_rready       (i_rready),
    .i_sample_valid (o_sample_valid),
    .o_enable       (enable),
    .o_freq_a       (freq_a),
    .o_freq_b       (freq_b),
    .o_amp_a        (amp_a),
    .o_amp_b        (amp_b)
  );

  // Both channels share the enable so their frames stay aligned
  tone_channel tone_a_inst (
    .i_clk    (i_clk),
    .i_rst_an (i_rst_an),
    .i_enable (enable),
    .i_freq   (freq_a),
    .o_sin    (sin_a),
    .o_valid  (valid_a)
  );

  tone_channel tone_b_inst (
    .i_clk    (i_clk),
    .i_rst_an (i_rst_an),
    .i_enable (enable),
    .i_freq   (freq_b),
    .o_sin    (sin_b),
    .o_valid  (valid_b)
  );

  tone_mixer tone_mixer_inst (
    .i_clk          (i_clk),
    .i_rst_an       (i_rst_an),
    .i_sin_a        (sin_a),
    .i_sin_b        (sin_b),
    .i_valid_a      (valid_a),
    .i_valid_b      (valid_b),
    .i_amp_a        (amp_a),
    .i_amp_b        (amp_b),
    .o_sample       (o_sample),
    .o_sample_valid (o_sample_valid),
    .o_sat          (o_sat)
  );

endmodule

/* logic/tone_channel.sv */
// One tone channel
// Phase accumulator and 18-cycle sample frame around a CORDIC rotator

`include "tone_params.svh"

module tone_channel (
  input  logic              i_clk,
  input  logic              i_rst_an,
  input  logic              i_enable,
  input  tone_pkg::phase_t  i_freq,
  output tone_pkg::sample_t o_sin,
  output logic              o_valid
);

  // Load, iterations, result
  localparam int c_frame_len = `TONE_NR_ITER + 2;
  localparam int c_frame_w   = $clog2(c_frame_len);

  localparam logic [c_frame_w-1:0] c_frame_last = c_frame_w'(c_frame_len - 1);

  tone_pkg::phase_t     r_phase;
  logic [c_frame_w-1:0] r_frame;
  logic                 load;

  // Frame slot 0 starts a new sample while enabled
  assign load = i_enable && (r_frame == '0);

  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      r_phase <= '0;
      r_frame <= '0;
    end
    else if (load)
    begin
      r_phase <= r_phase + i_freq;
      r_frame <= c_frame_w'(1);
    end
    else if (r_frame != '0)
    begin
      r_frame <= (r_frame == c_frame_last) ? '0 : r_frame + 1'b1;
    end
    else
    begin
      // Idle until the next enable restarts from phase 0
      r_phase <= '0;
    end
  end

  cordic_rotator #(
    .nr_iter (`TONE_NR_ITER)
  ) rotator_inst (
    .i_clk    (i_clk),
    .i_rst_an (i_rst_an),
    .i_start  (load),
    .i_phase  (r_phase),
    .o_sin    (o_sin),
    .o_done   (o_valid)
  );

  a_valid_in_last_slot: assert property (
    @(posedge i_clk) disable iff (!i_rst_an) o_valid |-> r_frame == c_frame_last);

endmodule

/* logic/tone_mixer.sv */
// Two-channel mixer
// Removes the CORDIC gain, scales each tone by its amplitude,
// sums both and saturates to a 16-bit registered sample

`include "tone_params.svh"

module tone_mixer (
  input  logic              i_clk,
  input  logic              i_rst_an,
  input  tone_pkg::sample_t i_sin_a,
  input  tone_pkg::sample_t i_sin_b,
  input  logic              i_valid_a,
  input  logic              i_valid_b,
  input  tone_pkg::amp_t    i_amp_a,
  input  tone_pkg::amp_t    i_amp_b,
  output tone_pkg::sample_t o_sample,
  output logic              o_sample_valid,
  output logic              o_sat
);

  localparam int c_w    = `TONE_XY_W;
  localparam int c_frac = c_w - 1;

  // round(0.607253 * 2^15)
  localparam logic signed [c_w-1:0] c_gain = 16'sd19898;

  localparam logic signed [c_w+1:0] c_max = (c_w+2)'(2 ** (c_w - 1) - 1);
  localparam logic signed [c_w+1:0] c_min = -(c_w+2)'(2 ** (c_w - 1));

  // Gain compensation then amplitude as two Q15 products
  function automatic logic signed [c_w:0] scale(
    input tone_pkg::sample_t sin_val,
    input tone_pkg::amp_t    amp
  );
    logic signed [2*c_w-1:0] prod_gain;
    logic signed [2*c_w-1:0] prod_amp;
    logic signed [c_w-1:0]   comp;
    prod_gain = sin_val * c_gain;
    comp      = prod_gain[c_frac +: c_w];
    prod_amp  = comp * amp;
    return prod_amp[2*c_w-1:c_frac];
  endfunction

  logic signed [c_w:0]   term_a;
  logic signed [c_w:0]   term_b;
  logic signed [c_w+1:0] sum;
  logic                  clip_hi;
  logic                  clip_lo;
  logic                  both_valid;

  assign term_a     = scale(i_sin_a, i_amp_a);
  assign term_b     = scale(i_sin_b, i_amp_b);
  assign sum        = term_a + term_b;
  assign clip_hi    = sum > c_max;
  assign clip_lo    = sum < c_min;
  assign both_valid = i_valid_a && i_valid_b;

  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      o_sample_valid <= 1'b0;
      o_sat          <= 1'b0;
    end
    else
    begin
      o_sample_valid <= both_valid;
      o_sat          <= both_valid && (clip_hi || clip_lo);
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (both_valid)
    begin
      if (clip_hi)
        o_sample <= c_max[c_w-1:0];
      else if (clip_lo)
        o_sample <= c_min[c_w-1:0];
      else
        o_sample <= sum[c_w-1:0];
    end
  end

  // Both channels share one enable, so their frames line up
  a_valid_aligned: assert property (
    @(posedge i_clk) disable iff (!i_rst_an) i_valid_a == i_valid_b);

endmodule

/* logic/tone_pkg.sv */
// Dual-tone generator shared types
// Phase, sample and amplitude types plus AXI response codes

`include "tone_params.svh"

package tone_pkg;

  // -------------------------------------------------------------------------
  // Datapath types
  // -------------------------------------------------------------------------

  // Unsigned phase that wraps at 2^16
  typedef logic [`TONE_PHASE_W-1:0] phase_t;

  // Sine values and the mixed output sample
  typedef logic signed [`TONE_XY_W-1:0] sample_t;

  // Q1.15 channel amplitude
  typedef logic signed [`TONE_XY_W-1:0] amp_t;

  // -------------------------------------------------------------------------
  // AXI4-Lite response codes
  // -------------------------------------------------------------------------

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_t;

endpackage
